//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_spi_master
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
BIN       ?= sim_bin
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(BIN)
	./$(OBJ_DIR)/$(BIN) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- filelist.f
spi_pkg.sv
spi_bit_engine.sv
spi_cmd_ctrl.sv
spi_master_top.sv
spi_slave_model.sv
spi_assertions.sv
tb_spi_master.sv

//--- spi_assertions.sv
`timescale 1ns/10ps

module spi_assertions
  import spi_pkg::*;
(
  input logic     clk,
  input logic     rst_n,
  input spi_bus_s bus,
  input logic     read_vld,
  input logic     cmd_rdy
);

  // sclk idles low outside a frame.
  cs_high_sclk_low: assert property (@(posedge clk) disable iff (!rst_n)
    bus.cs_n |-> !bus.sclk)
    else $error("sclk high while cs_n is high");

  read_vld_single: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else $error("read_vld high on two consecutive cycles");

  busy_while_selected: assert property (@(posedge clk) disable iff (!rst_n)
    !bus.cs_n |-> !cmd_rdy)
    else $error("cmd_rdy high while cs_n is low");

endmodule

bind spi_master_top spi_assertions u_assertions (
  .clk      (clk),
  .rst_n    (rst_n),
  .bus      (bus),
  .read_vld (read_vld),
  .cmd_rdy  (cmd_rdy)
);

//--- spi_bit_engine.sv
`timescale 1ns/10ps

module spi_bit_engine
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  frame_req_s            req,
  input  logic                  miso,
  output logic                  sclk,
  output logic                  mosi,
  output logic                  frame_done,
  output logic [data_width-1:0] rx_word
);

  logic                   active;
  logic [div_width-1:0]   div_cnt;
  logic [nbits_width-1:0] bit_cnt;
  logic [nbits_width-1:0] nbits_q;
  logic [cmd_width-1:0]   tx_sh;
  logic                   half_tick;
  logic                   last_bit;

  assign half_tick = active && (div_cnt == div_last);
  assign last_bit  = (bit_cnt == nbits_q - 1'b1);

  // divider, sclk and bit count.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active     <= 1'b0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      sclk       <= 1'b0;
      mosi       <= 1'b0;
      frame_done <= 1'b0;
    end
    else
    begin
      frame_done <= 1'b0;
      if (req.start)
      begin
        active  <= 1'b1;
        div_cnt <= '0;
        bit_cnt <= '0;
        sclk    <= 1'b0;
        mosi    <= req.tx_word[0]; // first bit ahead of the first rising edge.
      end
      else if (active)
      begin
        div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
        if (half_tick)
        begin
          sclk <= ~sclk;
          if (sclk) // falling edge.
          begin
            if (last_bit)
            begin
              active     <= 1'b0;
              mosi       <= 1'b0;
              frame_done <= 1'b1;
            end
            else
            begin
              bit_cnt <= bit_cnt + 1'b1;
              mosi    <= tx_sh[0];
            end
          end
        end
      end
    end
  end

  // shift registers.
  always_ff @(posedge clk)
  begin
    if (req.start)
    begin
      nbits_q <= req.nbits;
      tx_sh   <= req.tx_word >> 1;
    end
    else if (half_tick)
    begin
      if (!sclk)
        rx_word <= {miso, rx_word[data_width-1:1]}; // sampled on the rising edge.
      else
        tx_sh <= tx_sh >> 1;
    end
  end

endmodule

//--- spi_cmd_ctrl.sv
`timescale 1ns/10ps

module spi_cmd_ctrl
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_u              cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output frame_req_s            frame_req,
  input  logic                  frame_done,
  input  logic [data_width-1:0] rx_word,
  output logic                  cs_n,
  output logic                  read_vld,
  output logic [data_width-1:0] read_data
);

  typedef enum logic [2:0] {
    s_idle,
    s_wr_frame,
    s_rd_addr,
    s_gap,
    s_rd_data,
    s_release
  } state_e;

  state_e                state;
  spi_cmd_u              cmd_q;
  logic [data_width-1:0] gap_cnt;
  logic                  accept;

  assign cmd_rdy = (state == s_idle);
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= s_idle;
      cs_n      <= 1'b1;
      read_vld  <= 1'b0;
      frame_req <= '0;
      gap_cnt   <= '0;
    end
    else
    begin
      frame_req.start <= 1'b0;
      read_vld        <= 1'b0;
      case (state)
        s_idle:
        begin
          if (accept)
          begin
            cs_n            <= 1'b0;
            frame_req.start <= 1'b1;
            if (cmd_in.wr.is_write)
            begin
              state             <= s_wr_frame;
              frame_req.nbits   <= nbits_width'(cmd_width);
              frame_req.tx_word <= {cmd_in.wr.is_write, cmd_in.wr.addr, cmd_in.wr.wdata};
            end
            else
            begin
              // address phase carries flag and address only.
              state             <= s_rd_addr;
              frame_req.nbits   <= nbits_width'(rd_addr_bits);
              frame_req.tx_word <= {{(cmd_width - rd_addr_bits){1'b0}},
                                    cmd_in.rd.is_write, cmd_in.rd.addr};
            end
          end
        end
        s_wr_frame:
        begin
          if (frame_done)
          begin
            cs_n  <= 1'b1;
            state <= s_release;
          end
        end
        s_rd_addr:
        begin
          if (frame_done)
          begin
            cs_n    <= 1'b1;
            gap_cnt <= cmd_q.rd.gap;
            state   <= s_gap;
          end
        end
        s_gap:
        begin
          if (gap_cnt == '0) // cs_n has been high for gap+1 clocks.
          begin
            cs_n              <= 1'b0;
            frame_req.start   <= 1'b1;
            frame_req.nbits   <= nbits_width'(data_width);
            frame_req.tx_word <= '0;
            state             <= s_rd_data;
          end
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        s_rd_data:
        begin
          if (frame_done)
          begin
            cs_n     <= 1'b1;
            read_vld <= 1'b1;
            state    <= s_release;
          end
        end
        s_release:
          state <= s_idle;
        default:
        begin
          cs_n  <= 1'b1;
          state <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if ((state == s_rd_data) && frame_done)
      read_data <= rx_word; // held until the next read.
  end

endmodule

//--- spi_master_top.sv
`timescale 1ns/10ps

module spi_master_top
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_u              cmd_in,
  input  logic                  cmd_vld,
  output logic                  cmd_rdy,
  output spi_bus_s              bus,
  input  logic                  miso,
  output logic                  read_vld,
  output logic [data_width-1:0] read_data
);

  frame_req_s            frame_req;
  logic                  frame_done;
  logic [data_width-1:0] rx_word;
  logic                  cs_n;
  logic                  sclk;
  logic                  mosi;

  spi_cmd_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_in     (cmd_in),
    .cmd_vld    (cmd_vld),
    .cmd_rdy    (cmd_rdy),
    .frame_req  (frame_req),
    .frame_done (frame_done),
    .rx_word    (rx_word),
    .cs_n       (cs_n),
    .read_vld   (read_vld),
    .read_data  (read_data)
  );

  spi_bit_engine u_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (frame_req),
    .miso       (miso),
    .sclk       (sclk),
    .mosi       (mosi),
    .frame_done (frame_done),
    .rx_word    (rx_word)
  );

  assign bus = '{sclk: sclk, cs_n: cs_n, mosi: mosi}; // cs_n from the sequencer.

endmodule

//--- spi_pkg.sv
package spi_pkg;

  localparam int cmd_width    = 12; // full command word.
  localparam int data_width   = 8;  // read and write payload.
  localparam int addr_width   = 3;
  localparam int sclk_half    = 4;  // clocks per sclk half period.
  localparam int rd_addr_bits = 4;  // flag plus address.
  localparam int nbits_width  = 4;  // frame length field.

  // sclk divider counter.
  localparam int div_width = $clog2(sclk_half);
  localparam logic [div_width-1:0] div_last = div_width'(sclk_half - 1);

  // write command sent whole and lsb first.
  typedef struct packed {
    logic                  is_write;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
  } spi_cmd_wr_s;

  // read command with the turnaround gap in clocks in the low byte.
  typedef struct packed {
    logic                  is_write;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] gap;
  } spi_cmd_rd_s;

  typedef union packed {
    spi_cmd_wr_s wr;
    spi_cmd_rd_s rd;
  } spi_cmd_u;

  // pins toward the slave.
  typedef struct packed {
    logic sclk;
    logic cs_n;
    logic mosi;
  } spi_bus_s;

  // one frame request from the sequencer to the bit engine.
  typedef struct packed {
    logic                   start;   // one-cycle pulse.
    logic [nbits_width-1:0] nbits;
    logic [cmd_width-1:0]   tx_word;
  } frame_req_s;

endpackage

//--- spi_slave_model.sv
`timescale 1ns/10ps

module spi_slave_model
  import spi_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  spi_bus_s bus,
  output logic     miso
);

  logic [data_width-1:0] regs [2**addr_width];
  logic [cmd_width-1:0]  rx_sh;
  logic [3:0]            rx_cnt;
  logic [addr_width-1:0] rd_addr;
  logic                  rd_armed;
  logic [data_width-1:0] tx_sh;
  logic                  sclk_q;
  logic                  cs_q;

  // bus edges are found by sampling on the system clock.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 2**addr_width; i++)
        regs[i] <= 8'ha0 + 8'(i);
      rx_sh    <= '0;
      rx_cnt   <= '0;
      rd_addr  <= '0;
      rd_armed <= 1'b0;
      tx_sh    <= '0;
      sclk_q   <= 1'b0;
      cs_q     <= 1'b1;
      miso     <= 1'b0;
    end
    else
    begin
      sclk_q <= bus.sclk;
      cs_q   <= bus.cs_n;
      if (cs_q && !bus.cs_n) // frame opens.
      begin
        rx_cnt <= '0;
        if (rd_armed)
        begin
          miso  <= regs[rd_addr][0];
          tx_sh <= regs[rd_addr] >> 1;
        end
      end
      else if (!cs_q && bus.cs_n) // frame closes.
      begin
        if (rx_cnt == 4'(cmd_width) && rx_sh[cmd_width-1])
          regs[rx_sh[cmd_width-2 -: addr_width]] <= rx_sh[data_width-1:0];
        if (rx_cnt == 4'(rd_addr_bits))
          rd_addr <= rx_sh[cmd_width-2 -: addr_width];
        rd_armed <= (rx_cnt == 4'(rd_addr_bits)) && !rx_sh[cmd_width-1];
        miso     <= 1'b0;
      end
      else if (!bus.cs_n)
      begin
        if (!sclk_q && bus.sclk)
        begin
          rx_sh  <= {bus.mosi, rx_sh[cmd_width-1:1]}; // lsb arrives first.
          rx_cnt <= rx_cnt + 1'b1;
        end
        else if (sclk_q && !bus.sclk && rd_armed)
        begin
          miso  <= tx_sh[0];
          tx_sh <= tx_sh >> 1;
        end
      end
    end
  end

endmodule

//--- tb_spi_master.sv
`timescale 1ns/10ps

module tb_spi_master
  import spi_pkg::*;
();

  localparam int n_random      = 40;
  localparam int clks_per_test = 400;

  logic                  clk = 1'b0;
  logic                  rst_n;
  spi_cmd_u              cmd_in;
  logic                  cmd_vld;
  logic                  cmd_rdy;
  spi_bus_s              bus;
  logic                  miso;
  logic                  read_vld;
  logic [data_width-1:0] read_data;

  string                 names[$];
  spi_cmd_u              cmds[$];
  bit                    want_read[$];
  bit                    holds[$]; // keep cmd_vld up into the next entry.
  logic [data_width-1:0] shadow [2**addr_width];
  int                    errors = 0;
  int                    accept_cnt = 0;
  int                    high_run = 0;
  int                    gap_seen = 0;
  bit                    table_ready = 1'b0;

  always #50 clk = ~clk;

  spi_master_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .bus       (bus),
    .miso      (miso),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model u_slave (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus),
    .miso  (miso)
  );

  // accepted commands and length of the last cs_n high run.
  always @(posedge clk)
  begin
    if (cmd_vld && cmd_rdy)
      accept_cnt <= accept_cnt + 1;
    if (bus.cs_n)
      high_run <= high_run + 1;
    else if (high_run != 0)
    begin
      gap_seen <= high_run;
      high_run <= 0;
    end
  end

  function automatic spi_cmd_u wr_cmd(input logic [addr_width-1:0] addr,
                                      input logic [data_width-1:0] data);
    spi_cmd_u c;
    c.wr.is_write = 1'b1;
    c.wr.addr     = addr;
    c.wr.wdata    = data;
    return c;
  endfunction

  function automatic spi_cmd_u rd_cmd(input logic [addr_width-1:0] addr,
                                      input logic [data_width-1:0] gap);
    spi_cmd_u c;
    c.rd.is_write = 1'b0;
    c.rd.addr     = addr;
    c.rd.gap      = gap;
    return c;
  endfunction

  function automatic void add_entry(input string name, input spi_cmd_u cmd, input bit hold);
    names.push_back(name);
    cmds.push_back(cmd);
    want_read.push_back(!cmd.wr.is_write);
    holds.push_back(hold);
  endfunction

  task automatic build_table();
    add_entry("rd_reset_0", rd_cmd(3'd0, 8'd2), 1'b0);
    add_entry("rd_reset_5", rd_cmd(3'd5, 8'd1), 1'b0);
    add_entry("wr_3", wr_cmd(3'd3, 8'h5c), 1'b0);
    add_entry("rd_3_written", rd_cmd(3'd3, 8'd3), 1'b0);
    add_entry("rd_2_unchanged", rd_cmd(3'd2, 8'd0), 1'b0);
    add_entry("rd_4_unchanged", rd_cmd(3'd4, 8'd1), 1'b0);
    add_entry("rd_gap_0", rd_cmd(3'd3, 8'd0), 1'b0);
    add_entry("rd_gap_5", rd_cmd(3'd3, 8'd5), 1'b0);
    add_entry("rd_gap_200", rd_cmd(3'd3, 8'd200), 1'b0);
    add_entry("held_wr_1", wr_cmd(3'd1, 8'h3e), 1'b1);
    add_entry("held_wr_6", wr_cmd(3'd6, 8'hc1), 1'b1);
    add_entry("held_wr_7", wr_cmd(3'd7, 8'h81), 1'b1);
    add_entry("held_rd_6", rd_cmd(3'd6, 8'd2), 1'b1);
    add_entry("held_rd_1", rd_cmd(3'd1, 8'd0), 1'b0);
    add_entry("rd_7", rd_cmd(3'd7, 8'd4), 1'b0);
    for (int i = 0; i < n_random; i++)
    begin
      if ($urandom_range(1) == 1)
        add_entry($sformatf("rand_wr_%0d", i),
                  wr_cmd(addr_width'($urandom), data_width'($urandom)), 1'b0);
      else
        add_entry($sformatf("rand_rd_%0d", i),
                  rd_cmd(addr_width'($urandom), data_width'($urandom_range(15))), 1'b0);
    end
  endtask

  task automatic check_reset_state();
    if (bus !== 3'b010) // sclk low, cs_n high, mosi low.
    begin
      $display("ERR reset_state bus expected 010 actual %b", bus);
      errors++;
    end
    else if ({cmd_rdy, read_vld} !== 2'b10)
    begin
      $display("ERR reset_state rdy_vld expected 10 actual %b%b", cmd_rdy, read_vld);
      errors++;
    end
    else
      $display("reset_state ok");
  endtask

  task automatic run_entry(input int i);
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] expect_val;
    int                    min_gap;
    bit                    ok;
    addr = cmds[i].wr.addr;
    ok   = 1'b1;
    if (i == 0 || !holds[i-1])
    begin
      @(negedge clk);
      cmd_in  = cmds[i];
      cmd_vld = 1'b1;
    end
    while (!cmd_rdy)
      @(negedge clk);
    @(negedge clk); // taken on the rising edge just passed.
    if (holds[i] && i + 1 < names.size())
      cmd_in = cmds[i+1];
    else
      cmd_vld = 1'b0;
    if (want_read[i])
    begin
      while (!read_vld)
        @(negedge clk);
      expect_val = shadow[addr];
      min_gap    = int'(cmds[i].rd.gap) + 1;
      if (read_data !== expect_val)
      begin
        $display("ERR %s expected %02h actual %02h", names[i], expect_val, read_data);
        ok = 1'b0;
      end
      if (gap_seen < min_gap)
      begin
        $display("ERR %s gap expected >= %0d actual %0d", names[i], min_gap, gap_seen);
        ok = 1'b0;
      end
    end
    else
    begin
      while (!cmd_rdy)
        @(negedge clk);
      shadow[addr] = cmds[i].wr.wdata;
    end
    if (accept_cnt != i + 1)
    begin
      $display("ERR %s accepts expected %0d actual %0d", names[i], i + 1, accept_cnt);
      ok = 1'b0;
    end
    if (ok)
      $display("%s ok", names[i]);
    else
      errors++;
  endtask

  initial
  begin
    void'($urandom(32'ha151));
    rst_n   = 1'b0;
    cmd_vld = 1'b0;
    cmd_in  = '0;
    for (int a = 0; a < 2**addr_width; a++)
      shadow[a] = 8'ha0 + 8'(a);
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_reset_state();
    for (int i = 0; i < names.size(); i++)
      run_entry(i);
    repeat (4) @(negedge clk);
    $display("tests %0d errors %0d", names.size() + 1, errors);
    if (errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // watchdog.
  initial
  begin
    wait (table_ready);
    repeat (names.size() * clks_per_test + 20) @(posedge clk);
    $display("timeout: transfers did not complete in time");
    $display("Regression failed");
    $finish;
  end

endmodule
